/* flist.f */
hw/vrc6_pkg.sv
hw/vrc6_bank_regs.sv
hw/vrc_irq.sv
hw/vrc6_pulse.sv
hw/vrc6_saw.sv
hw/vrc6_mapper.sv
tb/vrc6_model.sv
tb/vrc6_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the VRC6 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module vrc6_tb -f flist.f -o vrc6_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/vrc6_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
echo "Pass message not found"
exit 1

/* tb/vrc6_tb.sv */
// ======================================================================
// VRC6 mapper testbench
// ======================================================================

module vrc6_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import vrc6_pkg::*;

	localparam int MAX_CPU_CYCLES = 4000;
	localparam time WATCHDOG_NS = MAX_CPU_CYCLES * 4 * 8 + 1000;

	logic      clk = 0;
	logic      arst_n;
	logic      ce;
	cpu_bus_t  cpu;
	ppu_addr_t chr_addr;
	audio_t    audio_in;
	mem_port_t prg;
	mem_port_t exp_prg;
	mem_addr_t chr_mem_addr;
	mem_addr_t exp_chr;
	logic      vram_a10;
	logic      vram_ce;
	logic      irq;
	logic      exp_a10;
	logic      exp_vce;
	logic      exp_irq;
	audio_t    audio_out;
	audio_t    exp_audio;
	logic      checking = 0;
	logic [31:0] lfsr = 32'hfd00_515f;
	logic      seen;

	vrc6_mapper dut (
		.clk(clk), .arst_n(arst_n), .ce(ce), .cpu(cpu), .chr_addr(chr_addr),
		.audio_in(audio_in), .prg(prg), .chr_mem_addr(chr_mem_addr),
		.vram_a10(vram_a10), .vram_ce(vram_ce), .irq(irq), .audio_out(audio_out)
	);

	vrc6_model model (
		.clk(clk), .arst_n(arst_n), .ce(ce), .cpu(cpu), .chr_addr(chr_addr),
		.audio_in(audio_in), .prg(exp_prg), .chr_mem_addr(exp_chr),
		.vram_a10(exp_a10), .vram_ce(exp_vce), .irq(exp_irq), .audio_out(exp_audio)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the test did not finish in time");
		$display("Errors found");
		$fatal(1);
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic report(input string sig, input logic [31:0] got, input logic [31:0] want);
		$display("Error: %0t ns %s got %h expected %h", $time, sig, got, want);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compare_outputs();
		if (checking) begin
			assert (prg == exp_prg) else report("prg", prg, exp_prg);
			assert (chr_mem_addr == exp_chr) else report("chr_mem_addr", chr_mem_addr, exp_chr);
			assert (vram_a10 == exp_a10) else report("vram_a10", vram_a10, exp_a10);
			assert (vram_ce == exp_vce) else report("vram_ce", vram_ce, exp_vce);
			assert (irq == exp_irq) else report("irq", irq, exp_irq);
			assert (audio_out == exp_audio) else report("audio_out", audio_out, exp_audio);
		end
	endtask

	// One CPU cycle of four clocks with ce and write on the last
	task automatic cpu_cycle(input logic wr, input cpu_addr_t a, input byte_t d,
		input ppu_addr_t p, input audio_t aud);
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			compare_outputs();
			ce        = (k == 3);
			cpu.write = wr && (k == 3);
			cpu.addr  = a;
			cpu.data  = d;
			chr_addr  = p;
			audio_in  = aud;
		end
	endtask

	task automatic write_reg(input cpu_addr_t a, input byte_t d);
		cpu_cycle(1'b1, a, d, ppu_addr_t'(next_bits(13)), audio_t'(next_bits(16)));
	endtask

	task automatic idle_cycle();
		cpu_cycle(1'b0, 16'h0000, 8'h00, ppu_addr_t'(next_bits(14)), audio_t'(next_bits(16)));
	endtask

	task automatic wait_irq(input int limit, output logic got);
		got = 0;
		for (int i = 0; i < limit && !got; i++) begin
			idle_cycle();
			got = irq;
		end
	endtask

	initial begin
		arst_n = 0;
		ce = 0;
		cpu = '0;
		chr_addr = '0;
		audio_in = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1;
		checking = 1;

		// Reset state with silent channels
		for (int i = 0; i < 10; i++) idle_cycle();
		assert (!irq) else report("irq after reset", irq, 0);

		// Bank writes and random accesses
		for (int i = 0; i < 60; i++) begin
			case (next_bits(2))
				0: write_reg(cpu_addr_t'(16'h8000 | next_bits(2)), byte_t'(next_bits(8)));
				1: write_reg(cpu_addr_t'(16'hC000 | next_bits(2)), byte_t'(next_bits(8)));
				2: write_reg(cpu_addr_t'(16'hD000 | next_bits(2)), byte_t'(next_bits(8)));
				default: write_reg(cpu_addr_t'(16'hE000 | next_bits(2)), byte_t'(next_bits(8)));
			endcase
			for (int j = 0; j < 3; j++) begin
				cpu_cycle(1'(next_bits(1)) && next_bits(1), cpu_addr_t'(next_bits(16)),
					8'h00, ppu_addr_t'(next_bits(13)), audio_t'(next_bits(16)));
			end
		end

		// Mirroring modes on nametable fetches
		for (int m = 0; m < 4; m++) begin
			write_reg(16'hB003, byte_t'(m << 2));
			for (int j = 0; j < 16; j++) begin
				cpu_cycle(1'b0, 16'h0000, 8'h00, ppu_addr_t'(14'h2000 | next_bits(12)), 16'h0);
			end
		end

		// Cycle mode IRQ re-armed by acknowledge
		write_reg(16'hF000, 8'hF0);
		write_reg(16'hF001, 8'h07);
		wait_irq(100, seen);
		assert (seen) else begin
			$display("IRQ never rose in cycle mode");
			$display("Errors found");
			$fatal(1);
		end
		write_reg(16'hF002, 8'h00);
		wait_irq(100, seen);
		assert (seen) else begin
			$display("IRQ did not fire again after acknowledge");
			$display("Errors found");
			$fatal(1);
		end
		write_reg(16'hF001, 8'h06);
		wait_irq(100, seen);
		write_reg(16'hF002, 8'h00);
		wait_irq(60, seen);
		assert (!seen) else report("irq after ack with enable-after-ack clear", 1, 0);

		// Scanline mode up to one wrap
		write_reg(16'hF000, 8'hFE);
		write_reg(16'hF001, 8'h02);
		wait_irq(400, seen);
		assert (seen) else begin
			$display("IRQ never rose in scanline mode");
			$display("Errors found");
			$fatal(1);
		end

		// Expansion sound
		write_reg(16'h9000, byte_t'(8'h80 | next_bits(4)));
		write_reg(16'h9001, byte_t'(next_bits(5)));
		write_reg(16'h9002, 8'h80);
		write_reg(16'hA000, byte_t'(8'h80 | next_bits(4)));
		write_reg(16'hA001, byte_t'(next_bits(5)));
		write_reg(16'hA002, 8'h80);
		write_reg(16'hB000, byte_t'(next_bits(6)));
		write_reg(16'hB001, byte_t'(next_bits(4)));
		write_reg(16'hB002, 8'h80);
		for (int i = 0; i < 400; i++) idle_cycle();
		write_reg(16'h9000, byte_t'(next_bits(8)));
		for (int i = 0; i < 200; i++) idle_cycle();

		$display("No errors");
		$finish;
	end

endmodule

/* tb/vrc6_model.sv */
// ======================================================================
// VRC6 reference model
// ======================================================================

module vrc6_model (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  vrc6_pkg::cpu_bus_t  cpu,
	input  vrc6_pkg::ppu_addr_t chr_addr,
	input  vrc6_pkg::audio_t    audio_in,
	output vrc6_pkg::mem_port_t prg,
	output vrc6_pkg::mem_addr_t chr_mem_addr,
	output logic                vram_a10,
	output logic                vram_ce,
	output logic                irq,
	output vrc6_pkg::audio_t    audio_out
);
	timeunit 1ns;
	timeprecision 1ps;
	import vrc6_pkg::*;

	logic [4:0]  p8;
	logic [5:0]  pc;
	logic [1:0]  mir;
	byte_t       chr [8];
	byte_t       latch, count;
	int          pre, line;
	logic        mode, ack_en, en, tout;
	byte_t       sq_ctrl [2];     // Mode, duty, volume
	logic [11:0] sq_freq [2];
	logic [11:0] sq_div [2];
	logic        sq_en [2];
	logic [3:0]  sq_step [2];
	logic [5:0]  rate;
	logic [11:0] sfreq;
	logic        sen;
	int          sdiv, sstep;
	byte_t       acc;
	logic        wr, irq_pg;
	int          lvl [3];
	logic [15:0] e16;
	int          sum;
	byte_t       bank;
	logic [5:0]  pb;

	assign wr = ce && cpu.write;
	assign irq_pg = cpu.addr[15:12] == 4'hF;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			p8 <= 0; pc <= 0; mir <= 0;
			for (int i = 0; i < 8; i++) chr[i] <= 0;
			latch <= 0; count <= 0; pre <= 0; line <= 0;
			mode <= 0; ack_en <= 0; en <= 0; tout <= 0;
			for (int i = 0; i < 2; i++) begin
				sq_ctrl[i] <= 0; sq_freq[i] <= 0; sq_div[i] <= 0;
				sq_en[i] <= 0; sq_step[i] <= 0;
			end
			rate <= 0; sfreq <= 0; sen <= 0; sdiv <= 0; sstep <= 0; acc <= 0;
		end else begin
			if (wr) begin
				if (cpu.addr[15:12] == 4'h8) p8 <= cpu.data[4:0];
				if (cpu.addr[15:12] == 4'hC) pc <= cpu.data[5:0];
				if (cpu.addr[15:12] == 4'hB && cpu.addr[1:0] == 3) mir <= cpu.data[3:2];
				if (cpu.addr[15:12] == 4'hD) chr[cpu.addr[1:0]] <= cpu.data;
				if (cpu.addr[15:12] == 4'hE) chr[4 + cpu.addr[1:0]] <= cpu.data;
			end
			// IRQ counter steps first, writes below take priority
			if (ce && en) begin
				if (mode || pre == 0) begin
					if (count == 8'hFF) begin
						count <= latch;
						tout  <= 1'b1;
					end else begin
						count <= count + 1;
					end
				end
				if (pre == 0) begin
					pre  <= (line == 2) ? 112 : 113;
					line <= (line + 1) % 3;
				end else begin
					pre <= pre - 1;
				end
			end
			if (wr && irq_pg && cpu.addr[1:0] == 0) latch <= cpu.data;
			if (wr && irq_pg && cpu.addr[1:0] == 1) begin
				mode <= cpu.data[2]; ack_en <= cpu.data[0]; en <= cpu.data[1]; tout <= 0;
				if (cpu.data[1]) begin
					count <= latch; pre <= 113; line <= 0;
				end
			end
			if (wr && irq_pg && cpu.addr[1:0] == 2) begin
				en <= ack_en; tout <= 0;
			end
			// Sound channels advance on ce only
			if (ce) begin
				for (int i = 0; i < 2; i++) begin
					if (sq_en[i]) begin
						if (sq_div[i] == 0) begin
							sq_div[i] <= sq_freq[i]; sq_step[i] <= sq_step[i] + 1;
						end else sq_div[i] <= sq_div[i] - 1;
					end
					if (cpu.write && cpu.addr[15:12] == 9 + i && cpu.addr[11:2] == 0) begin
						if (cpu.addr[1:0] == 0) sq_ctrl[i] <= cpu.data;
						if (cpu.addr[1:0] == 1) sq_freq[i][7:0] <= cpu.data;
						if (cpu.addr[1:0] == 2) begin
							sq_en[i] <= cpu.data[7]; sq_freq[i][11:8] <= cpu.data[3:0];
						end
					end
				end
				if (sen) begin
					if (sdiv == 0) begin
						sdiv  <= 2 * sfreq + 1;
						sstep <= (sstep == 6) ? 0 : sstep + 1;
						acc   <= (sstep == 6) ? 8'd0 : acc + rate;
					end else sdiv <= sdiv - 1;
				end
				if (cpu.write && cpu.addr[15:12] == 4'hB && cpu.addr[11:2] == 0) begin
					if (cpu.addr[1:0] == 0) rate <= cpu.data[5:0];
					if (cpu.addr[1:0] == 1) sfreq[7:0] <= cpu.data;
					if (cpu.addr[1:0] == 2) begin
						sen <= cpu.data[7]; sfreq[11:8] <= cpu.data[3:0];
					end
				end
			end
		end
	end

	always_comb begin
		if (cpu.addr < 16'h6000) pb = 0;
		else if (cpu.addr < 16'hC000) pb = {p8, cpu.addr[13]};
		else if (cpu.addr < 16'hE000) pb = pc;
		else pb = 6'h3F;
		if (cpu.addr >= 16'h6000 && cpu.addr < 16'h8000) prg.addr = {9'h1E0, cpu.addr[12:0]};
		else prg.addr = {3'b000, pb, cpu.addr[12:0]};
		prg.allow = (cpu.addr >= 16'h8000 && !cpu.write) ||
			(cpu.addr >= 16'h6000 && cpu.addr < 16'h8000);
		bank = chr[chr_addr[12:10]];
		if (!chr_addr[13]) vram_a10 = bank[0];
		else if (mir == 0) vram_a10 = chr_addr[10];
		else if (mir == 1) vram_a10 = chr_addr[11];
		else vram_a10 = mir[0];
		vram_ce = chr_addr[13];
		chr_mem_addr = {3'b100, 1'b0, bank[7:1], vram_a10, chr_addr[9:0]};
		for (int i = 0; i < 2; i++) begin
			if (sq_en[i] && (sq_ctrl[i][7] || sq_step[i] <= sq_ctrl[i][6:4]))
				lvl[i] = sq_ctrl[i][3:0];
			else lvl[i] = 0;
		end
		lvl[2] = sen ? acc / 8 : 0;
		sum = lvl[0] + lvl[1] + lvl[2];
		e16 = {sum[5:0], sum[5:0], sum[5:2]};
		audio_out = 16'((audio_in + e16 / 2 + e16 / 8) / 2);
		irq = tout && en;
	end

endmodule

/* hw/vrc6_mapper.sv */
// ===================================================================
// VRC6 mapper top level
// ===================================================================

module vrc6_mapper (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  vrc6_pkg::cpu_bus_t  cpu,
	input  vrc6_pkg::ppu_addr_t chr_addr,
	input  vrc6_pkg::audio_t    audio_in,
	output vrc6_pkg::mem_port_t prg,
	output vrc6_pkg::mem_addr_t chr_mem_addr,
	output logic                vram_a10,
	output logic                vram_ce,
	output logic                irq,
	output vrc6_pkg::audio_t    audio_out
);
	import vrc6_pkg::*;

	logic        irq_page;
	sq_level_t   sq1_level;
	sq_level_t   sq2_level;
	saw_level_t  saw_level;
	logic [5:0]  exp_level;
	audio_t      exp_audio;
	logic [16:0] mixed;

	assign irq_page = (cpu.addr[15:12] == 4'hF);

	vrc6_bank_regs u_bank_regs (
		.clk          (clk),
		.arst_n       (arst_n),
		.ce           (ce),
		.cpu          (cpu),
		.chr_addr     (chr_addr),
		.prg          (prg),
		.chr_mem_addr (chr_mem_addr),
		.vram_a10     (vram_a10),
		.vram_ce      (vram_ce)
	);

	vrc_irq u_irq (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.write     (cpu.write),
		.latch_sel (irq_page && cpu.addr[1:0] == 2'd0),  // F000
		.ctrl_sel  (irq_page && cpu.addr[1:0] == 2'd1),  // F001
		.ack_sel   (irq_page && cpu.addr[1:0] == 2'd2),  // F002
		.data      (cpu.data),
		.irq       (irq)
	);

	vrc6_pulse #(.PAGE(PULSE1_PAGE)) u_pulse1 (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.cpu    (cpu),
		.level  (sq1_level)
	);

	vrc6_pulse #(.PAGE(PULSE2_PAGE)) u_pulse2 (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.cpu    (cpu),
		.level  (sq2_level)
	);

	vrc6_saw u_saw (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.cpu    (cpu),
		.level  (saw_level)
	);

	// Channels sum before the linear gain stage
	assign exp_level = {2'b00, sq1_level} + {2'b00, sq2_level} + {1'b0, saw_level};
	assign exp_audio = {exp_level, exp_level, exp_level[5:2]};

	// Expansion scaled to about 5/8 to sit at console level
	assign mixed     = {1'b0, audio_in} + {2'b00, exp_audio[15:1]} + {4'b0000, exp_audio[15:3]};
	assign audio_out = mixed[16:1];

endmodule

/* hw/vrc6_saw.sv */
// ===================================================================
// VRC6 sawtooth channel
// ===================================================================

module vrc6_saw (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ce,
	input  vrc6_pkg::cpu_bus_t   cpu,
	output vrc6_pkg::saw_level_t level
);
	import vrc6_pkg::*;

	logic [5:0]  rate;
	logic [11:0] freq;
	logic        enable;
	logic [12:0] divider;
	logic [2:0]  step;
	byte_t       acc;
	logic        reg_sel;

	assign reg_sel = cpu.write && (cpu.addr[15:12] == SAW_PAGE) && (cpu.addr[11:2] == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rate    <= '0;
			freq    <= '0;
			enable  <= 1'b0;
			divider <= '0;
			step    <= '0;
			acc     <= '0;
		end else if (ce) begin
			if (reg_sel) begin
				case (cpu.addr[1:0])
					2'd0: rate <= cpu.data[5:0];
					2'd1: freq[7:0] <= cpu.data;
					2'd2: begin
						enable     <= cpu.data[7];
						freq[11:8] <= cpu.data[3:0];
					end
					default: ;
				endcase
			end
			if (enable) begin
				if (divider != '0) begin
					divider <= divider - 13'd1;
				end else begin
					divider <= {freq, 1'b1};  // Two CPU clocks per step
					if (step == 3'd6) begin
						step <= '0;
						acc  <= '0;       // Ramp restarts
					end else begin
						step <= step + 3'd1;
						acc  <= acc + {2'b00, rate};
					end
				end
			end
		end
	end

	assign level = enable ? acc[7:3] : '0;

endmodule

/* hw/vrc6_pulse.sv */
// ===================================================================
// VRC6 pulse channel
// ===================================================================

module vrc6_pulse #(
	parameter logic [3:0] PAGE = vrc6_pkg::PULSE1_PAGE
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  vrc6_pkg::cpu_bus_t  cpu,
	output vrc6_pkg::sq_level_t level
);
	import vrc6_pkg::*;

	logic        mode;     // Constant volume when set
	logic [2:0]  duty;
	sq_level_t   volume;
	logic [11:0] freq;
	logic        enable;
	logic [11:0] divider;
	logic [3:0]  step;
	logic        reg_sel;

	// Offsets 0..2 of this channel's page
	assign reg_sel = cpu.write && (cpu.addr[15:12] == PAGE) && (cpu.addr[11:2] == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{mode, duty, volume} <= '0;
			freq    <= '0;
			enable  <= 1'b0;
			divider <= '0;
			step    <= '0;
		end else if (ce) begin
			if (reg_sel) begin
				case (cpu.addr[1:0])
					2'd0: {mode, duty, volume} <= cpu.data;
					2'd1: freq[7:0] <= cpu.data;
					2'd2: begin
						enable     <= cpu.data[7];
						freq[11:8] <= cpu.data[3:0];
					end
					default: ;
				endcase
			end
			if (enable) begin
				if (divider != '0) begin
					divider <= divider - 12'd1;
				end else begin
					divider <= freq;
					step    <= step + 4'd1;  // 16-step duty cycle
				end
			end
		end
	end

	assign level = (enable && (mode || step <= {1'b0, duty})) ? volume : '0;

endmodule

/* hw/vrc_irq.sv */
// ===================================================================
// VRC scanline/cycle IRQ counter
// ===================================================================

module vrc_irq (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            ce,
	input  logic            write,
	input  logic            latch_sel,
	input  logic            ctrl_sel,
	input  logic            ack_sel,
	input  vrc6_pkg::byte_t data,
	output logic            irq
);
	import vrc6_pkg::*;

	byte_t      latch;
	byte_t      count;
	logic [6:0] prescale;
	logic [1:0] line;        // Position in the 113/113/112 sequence
	logic       mode;        // Cycle mode when set
	logic       ack_enable;
	logic       enable;
	logic       timeout;
	logic       wr;
	logic       reload;
	logic       tick;
	logic       wrap;

	assign wr     = ce && write;
	assign reload = wr && ctrl_sel && data[1];
	assign tick   = mode || (prescale == '0);
	assign wrap   = tick && (count == IRQ_RELOAD_AT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			latch      <= '0;
			mode       <= 1'b0;
			ack_enable <= 1'b0;
		end else if (wr) begin
			if (latch_sel) begin
				latch <= data;  // F000
			end
			if (ctrl_sel) begin
				mode       <= data[2];  // F001
				ack_enable <= data[0];
			end
		end
	end

	// Prescaler and counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count    <= '0;
			prescale <= '0;
			line     <= '0;
		end else if (reload) begin
			count    <= latch;
			prescale <= PRESCALE_LONG;
			line     <= '0;
		end else if (ce && enable) begin
			if (prescale != '0) begin
				prescale <= prescale - 7'd1;
			end else begin
				prescale <= line[1] ? PRESCALE_SHORT : PRESCALE_LONG;
				line     <= line[1] ? 2'd0 : line + 2'd1;
			end
			if (tick) begin
				count <= (count == IRQ_RELOAD_AT) ? latch : count + 8'd1;
			end
		end
	end

	// Control and ack writes both clear the pending flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enable  <= 1'b0;
			timeout <= 1'b0;
		end else if (wr && ctrl_sel) begin
			enable  <= data[1];
			timeout <= 1'b0;
		end else if (wr && ack_sel) begin
			enable  <= ack_enable;  // F002
			timeout <= 1'b0;
		end else if (ce && enable && wrap) begin
			timeout <= 1'b1;
		end
	end

	assign irq = timeout && enable;

	// A new IRQ only follows a counter wrap
	a_irq_source: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(irq) |-> $past(ce && enable && wrap));

endmodule

/* hw/vrc6_bank_regs.sv */
// ===================================================================
// VRC6 bank registers and address mapping
// ===================================================================

module vrc6_bank_regs (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  vrc6_pkg::cpu_bus_t  cpu,
	input  vrc6_pkg::ppu_addr_t chr_addr,
	output vrc6_pkg::mem_port_t prg,
	output vrc6_pkg::mem_addr_t chr_mem_addr,
	output logic                vram_a10,
	output logic                vram_ce
);
	import vrc6_pkg::*;

	logic [4:0] prgbank8;      // 16 KB bank at 0x8000
	logic [5:0] prgbankC;      // 8 KB bank at 0xC000
	logic [1:0] mirror;
	byte_t      chr_bank [8];  // 1 KB CHR banks
	byte_t      chr_cur;
	logic [5:0] prg_bank;
	logic       prg_is_ram;
	logic       chr_a10;
	logic       reg_wr;

	assign reg_wr = ce && cpu.write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prgbank8 <= '0;
			prgbankC <= '0;
			mirror   <= '0;
			for (int i = 0; i < 8; i++) begin
				chr_bank[i] <= '0;
			end
		end else if (reg_wr) begin
			casez ({cpu.addr[15:12], cpu.addr[1:0]})
				6'b1000_??: prgbank8 <= cpu.data[4:0];                      // 800x
				6'b1100_??: prgbankC <= cpu.data[5:0];                      // C00x
				6'b1011_11: mirror <= cpu.data[3:2];                        // B003
				6'b1101_??: chr_bank[{1'b0, cpu.addr[1:0]}] <= cpu.data;    // D000-D003
				6'b1110_??: chr_bank[{1'b1, cpu.addr[1:0]}] <= cpu.data;    // E000-E003
				default: ;
			endcase
		end
	end

	// PRG bank select per 8 KB window
	always_comb begin
		casez (cpu.addr[15:13])
			3'b0??:  prg_bank = 6'd0;
			3'b10?:  prg_bank = {prgbank8, cpu.addr[13]};
			3'b110:  prg_bank = prgbankC;
			default: prg_bank = 6'h3F;  // Fixed last bank
		endcase
	end

	assign prg_is_ram = (cpu.addr[15:13] == 3'b011);  // 0x6000-0x7FFF

	assign prg.addr  = prg_is_ram ? {PRG_RAM_BASE, cpu.addr[12:0]}
	                              : {3'b000, prg_bank, cpu.addr[12:0]};
	assign prg.allow = (cpu.addr[15] && !cpu.write) || prg_is_ram;

	assign chr_cur = chr_bank[chr_addr[12:10]];

	// Pattern tables take A10 from the bank, nametables from mirroring
	always_comb begin
		if (!chr_addr[13]) begin
			chr_a10 = chr_cur[0];
		end else begin
			case (mirror)
				2'd0:    chr_a10 = chr_addr[10];  // Vertical
				2'd1:    chr_a10 = chr_addr[11];  // Horizontal
				2'd2:    chr_a10 = 1'b0;          // Single screen low
				default: chr_a10 = 1'b1;          // Single screen high
			endcase
		end
	end

	assign chr_mem_addr = {CHR_ROM_BASE, 1'b0, chr_cur[7:1], chr_a10, chr_addr[9:0]};
	assign vram_a10     = chr_a10;
	assign vram_ce      = chr_addr[13];

	// Mirroring only moves on a B003 write
	a_mirror_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!(reg_wr && cpu.addr[15:12] == 4'hB && cpu.addr[1:0] == 2'd3) |=> $stable(mirror));

endmodule

/* hw/vrc6_pkg.sv */
// ===================================================================
// VRC6 mapper types and constants
// ===================================================================

package vrc6_pkg;

	// Bus and memory widths
	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;   // Cartridge ROM/RAM space
	typedef logic [15:0] audio_t;

	// Expansion sound channel levels
	typedef logic [3:0]  sq_level_t;   // 0..15
	typedef logic [4:0]  saw_level_t;  // 0..31

	// CPU side access, sampled on ce
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;
		logic      write;
	} cpu_bus_t;

	// Translated memory access
	typedef struct packed {
		mem_addr_t addr;
		logic      allow;  // Memory may answer this access
	} mem_port_t;

	// Upper address bits of the 8 KB work RAM
	localparam logic [8:0] PRG_RAM_BASE = 9'h1E0;

	// CHR region tag on the top address bits
	localparam logic [2:0] CHR_ROM_BASE = 3'b100;

	// Scanline prescaler reloads, 113/113/112 averages 113.67 CPU clocks
	localparam logic [6:0] PRESCALE_LONG  = 7'd113;
	localparam logic [6:0] PRESCALE_SHORT = 7'd112;

	// IRQ counter value that reloads from the latch
	localparam logic [7:0] IRQ_RELOAD_AT = 8'd255;

	// Sound register pages, address bits 15..12
	localparam logic [3:0] PULSE1_PAGE = 4'h9;
	localparam logic [3:0] PULSE2_PAGE = 4'hA;
	localparam logic [3:0] SAW_PAGE    = 4'hB;

endpackage
